//--- project.f
verilog/vmem_pkg.sv
verilog/vmem_req_check.sv
verilog/vmem_burst_split.sv
verilog/vmem_cmd_fifo.sv
verilog/vmem_addrgen.sv
testbench/tb_vmem_addrgen.sv

//--- testbench/tb_vmem_addrgen.sv
// Self-checking testbench for the vector memory address generator, elaborated as the top module
`default_nettype none

module tb_vmem_addrgen;
  timeunit 1ns;
  timeprecision 1ps;

  import vmem_pkg::*;

  localparam int NumRows  = 10;
  // Table rows, plus the blocked retry and its accepted rerun
  localparam int NumTests = NumRows + 2;
  localparam int WaitMax  = 1500;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic                 is_load;
    logic [AddrWidth-1:0] addr;
    logic [VlWidth-1:0]   vl;
    vew_e                 vew;
    logic                 exp_err;
  } row_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_valid_i;
  logic                  req_ready_o;
  logic [IdWidth-1:0]    req_id_i;
  logic                  req_is_load_i;
  logic [AddrWidth-1:0]  req_addr_i;
  logic [VlWidth-1:0]    req_vl_i;
  vew_e                  req_vew_i;
  logic [NrVInsn-1:0]    vinsn_running_i;
  logic                  ack_o;
  logic                  error_o;
  logic [IdWidth-1:0]    ack_id_o;
  logic                  ar_valid_o;
  logic                  ar_ready_i;
  logic [AddrWidth-1:0]  ar_addr_o;
  logic [AxLenWidth-1:0] ar_len_o;
  logic [2:0]            ar_size_o;
  logic [1:0]            ar_burst_o;
  logic                  aw_valid_o;
  logic                  aw_ready_i;
  logic [AddrWidth-1:0]  aw_addr_o;
  logic [AxLenWidth-1:0] aw_len_o;
  logic [2:0]            aw_size_o;
  logic [1:0]            aw_burst_o;
  logic                  cmd_valid_o;
  logic                  cmd_ready_i;
  logic [AddrWidth-1:0]  cmd_addr_o;
  logic [AxLenWidth-1:0] cmd_len_o;
  logic                  cmd_is_load_o;

  row_t                  rows [NumRows];
  // Bursts as {addr, len, is_load}
  logic [CmdWidth-1:0]   exp_q [$];
  logic [CmdWidth-1:0]   ax_q [$];
  logic [CmdWidth-1:0]   cmd_q [$];
  int                    ack_count;
  logic [IdWidth-1:0]    ack_id_got;
  logic                  ack_err_got;
  int                    errors;
  int                    row_errs;
  int                    checks;
  int                    tests;
  int unsigned           seed_ret;

  vmem_addrgen u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errs++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  function automatic row_t make_row(input int id, input bit is_load, input logic [31:0] addr,
                                    input int vl, input vew_e vew, input bit exp_err);
    row_t r;
    r.id      = IdWidth'(id);
    r.is_load = is_load;
    r.addr    = addr;
    r.vl      = VlWidth'(vl);
    r.vew     = vew;
    r.exp_err = exp_err;
    return r;
  endfunction

  // Reference burst rule: beat-aligned start, end clipped at 4 KiB then at 256 beats
  task automatic build_bursts(input row_t r);
    longint unsigned addr;
    longint unsigned rem;
    longint unsigned esize;
    longint unsigned start;
    longint unsigned stop;
    longint unsigned beats;
    longint unsigned covered;
    addr  = r.addr;
    rem   = r.exp_err ? 0 : r.vl;
    esize = 64'd1 << r.vew;
    while (rem != 0) begin
      start = addr & ~64'h7;
      stop  = (addr + rem * esize - 1) | 64'h7;
      if ((stop >> 12) != (start >> 12)) begin
        stop = start | 64'hfff;
      end
      beats = (stop - start) / 8 + 1;
      if (beats > 256) begin
        beats = 256;
      end
      stop = start + beats * 8 - 1;
      // Partial elements at the burst end still count as covered
      covered = (stop - addr + esize) / esize;
      exp_q.push_back({addr[31:0], 8'(beats - 1), r.is_load});
      rem  = (covered >= rem) ? 0 : rem - covered;
      addr = stop + 1;
    end
  endtask

  task automatic drive_request(input row_t r);
    req_valid_i           = 1'b1;
    req_id_i              = r.id;
    req_is_load_i         = r.is_load;
    req_addr_i            = r.addr;
    req_vl_i              = r.vl;
    req_vew_i             = r.vew;
    // Sequencer marks the id running as it issues
    vinsn_running_i[r.id] = 1'b1;
  endtask

  task automatic run_row(input int idx, input row_t r, input bit hold);
    int n;
    bit accepted;
    exp_q.delete();
    ax_q.delete();
    cmd_q.delete();
    ack_count = 0;
    row_errs  = 0;
    build_bursts(r);
    @(negedge clk_i);
    drive_request(r);
    accepted = 1'b0;
    n = 0;
    while (!accepted && n < WaitMax) begin
      @(posedge clk_i);
      accepted = req_ready_o;
      n++;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (!accepted) begin
      errors++;
      row_errs++;
      $display("Request with id %0d was never accepted", r.id);
    end
    n = 0;
    while (ack_count == 0 && n < WaitMax) begin
      @(posedge clk_i);
      n++;
    end
    if (ack_count == 0) begin
      errors++;
      row_errs++;
      $display("No acknowledge arrived for id %0d", r.id);
    end
    // Commands may still sit in the FIFO after the acknowledge
    n = 0;
    while (cmd_q.size() < exp_q.size() && n < 200) begin
      @(posedge clk_i);
      n++;
    end
    repeat (3) @(negedge clk_i);
    if (!hold) begin
      vinsn_running_i[r.id] = 1'b0;
    end
    repeat (3) @(negedge clk_i);
    check_val("ack_o count", ack_count, 1);
    if (ack_count != 0) begin
      check_val("ack_id_o", ack_id_got, r.id);
      check_val("error_o", ack_err_got, r.exp_err);
    end
    check_val(r.is_load ? "ar bursts" : "aw bursts", ax_q.size(), exp_q.size());
    check_val("cmd pops", cmd_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      if (i < ax_q.size()) begin
        check_val(r.is_load ? "ar_addr_o" : "aw_addr_o", ax_q[i][40:9], exp_q[i][40:9]);
        check_val(r.is_load ? "ar_len_o" : "aw_len_o", ax_q[i][8:1], exp_q[i][8:1]);
        check_val("ax channel", ax_q[i][0], exp_q[i][0]);
      end
      if (i < cmd_q.size()) begin
        check_val("cmd_addr_o", cmd_q[i][40:9], exp_q[i][40:9]);
        check_val("cmd_len_o", cmd_q[i][8:1], exp_q[i][8:1]);
        check_val("cmd_is_load_o", cmd_q[i][0], exp_q[i][0]);
      end
    end
    tests++;
    $display("row %0d id %0d %s: %0d bursts, %s", idx, r.id, r.is_load ? "load" : "store",
             exp_q.size(), (row_errs == 0) ? "ok" : "mismatch");
  endtask

  // Same id again while the sequencer still reports it running
  task automatic blocked_retry(input row_t r);
    row_errs = 0;
    @(negedge clk_i);
    drive_request(r);
    repeat (20) begin
      @(posedge clk_i);
      check_val("req_ready_o", req_ready_o, 0);
    end
    @(negedge clk_i);
    req_valid_i           = 1'b0;
    vinsn_running_i[r.id] = 1'b0;
    repeat (2) @(negedge clk_i);
    tests++;
    $display("retry id %0d while running: %s", r.id, (row_errs == 0) ? "ok" : "mismatch");
  endtask

  // Random back-pressure on every ready input, from one fixed seed
  initial begin
    seed_ret = $urandom(32'h897a_83b9);
    forever begin
      @(negedge clk_i);
      ar_ready_i  <= ($urandom % 4) != 0;
      aw_ready_i  <= ($urandom % 3) != 0;
      cmd_ready_i <= ($urandom % 4) != 0;
    end
  end

  // Monitors for fired addresses, popped commands and acknowledges
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && ar_ready_i) begin
        ax_q.push_back({ar_addr_o, ar_len_o, 1'b1});
        check_val("ar_size_o", ar_size_o, 3);
        check_val("ar_burst_o", ar_burst_o, 1);
      end
      if (aw_valid_o && aw_ready_i) begin
        ax_q.push_back({aw_addr_o, aw_len_o, 1'b0});
        check_val("aw_size_o", aw_size_o, 3);
        check_val("aw_burst_o", aw_burst_o, 1);
      end
      if (cmd_valid_o && cmd_ready_i) begin
        cmd_q.push_back({cmd_addr_o, cmd_len_o, cmd_is_load_o});
      end
      if (ack_o) begin
        ack_count++;
        ack_id_got  = ack_id_o;
        ack_err_got = error_o;
      end
    end
  end

  initial begin
    repeat (NumTests * 2000) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles before all tests completed", NumTests * 2000);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_id_i        = '0;
    req_is_load_i   = 1'b0;
    req_addr_i      = '0;
    req_vl_i        = '0;
    req_vew_i       = EW8;
    vinsn_running_i = '0;
    ar_ready_i      = 1'b0;
    aw_ready_i      = 1'b0;
    cmd_ready_i     = 1'b0;
    errors          = 0;
    checks          = 0;
    tests           = 0;
    ack_count       = 0;

    // Single bursts inside one page
    rows[0] = make_row(0, 1'b1, 32'h0000_1000, 4, EW64, 1'b0);
    rows[1] = make_row(1, 1'b0, 32'h0000_2040, 16, EW32, 1'b0);
    // Page crossings
    rows[2] = make_row(2, 1'b1, 32'h0000_0ff0, 8, EW32, 1'b0);
    rows[3] = make_row(3, 1'b0, 32'h0000_3ffa, 5, EW16, 1'b0);
    // Over 256 beats
    rows[4] = make_row(4, 1'b1, 32'h0001_0000, 600, EW64, 1'b0);
    // Misaligned base, rejected
    rows[5] = make_row(5, 1'b0, 32'h0000_5002, 4, EW32, 1'b1);
    rows[6] = make_row(6, 1'b1, 32'h0000_6004, 3, EW8, 1'b0);
    // Zero length, acknowledged without traffic
    rows[7] = make_row(7, 1'b0, 32'h0000_7000, 0, EW8, 1'b0);
    rows[8] = make_row(2, 1'b0, 32'h0000_8ffc, 300, EW32, 1'b0);
    // Id kept running afterwards for the retry
    rows[9] = make_row(3, 1'b1, 32'h0000_a100, 32, EW16, 1'b0);

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < NumRows; i++) begin
      run_row(i, rows[i], i == NumRows - 1);
    end
    blocked_retry(rows[NumRows-1]);
    run_row(NumRows, rows[NumRows-1], 1'b0);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/vmem_addrgen.sv
// Top of the vector memory address generator, chains the check, burst split and command FIFO
`default_nettype none

module vmem_addrgen (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Sequencer request
  input  logic                             req_valid_i,
  output logic                             req_ready_o,
  input  logic [vmem_pkg::IdWidth-1:0]     req_id_i,
  input  logic                             req_is_load_i,
  input  logic [vmem_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic [vmem_pkg::VlWidth-1:0]     req_vl_i,
  input  vmem_pkg::vew_e                   req_vew_i,
  input  logic [vmem_pkg::NrVInsn-1:0]     vinsn_running_i,
  // Acknowledge
  output logic                             ack_o,
  output logic                             error_o,
  output logic [vmem_pkg::IdWidth-1:0]     ack_id_o,
  // AXI AR
  output logic                             ar_valid_o,
  input  logic                             ar_ready_i,
  output logic [vmem_pkg::AddrWidth-1:0]   ar_addr_o,
  output logic [vmem_pkg::AxLenWidth-1:0]  ar_len_o,
  output logic [2:0]                       ar_size_o,
  output logic [1:0]                       ar_burst_o,
  // AXI AW
  output logic                             aw_valid_o,
  input  logic                             aw_ready_i,
  output logic [vmem_pkg::AddrWidth-1:0]   aw_addr_o,
  output logic [vmem_pkg::AxLenWidth-1:0]  aw_len_o,
  output logic [2:0]                       aw_size_o,
  output logic [1:0]                       aw_burst_o,
  // Burst commands to the load/store units
  output logic                             cmd_valid_o,
  input  logic                             cmd_ready_i,
  output logic [vmem_pkg::AddrWidth-1:0]   cmd_addr_o,
  output logic [vmem_pkg::AxLenWidth-1:0]  cmd_len_o,
  output logic                             cmd_is_load_o
);

  import vmem_pkg::*;

  // Check to split
  logic                  acc_valid;
  logic                  acc_ready;
  logic                  acc_is_load;
  logic [AddrWidth-1:0]  acc_addr;
  logic [VlWidth-1:0]    acc_vl;
  vew_e                  acc_vew;
  logic                  acc_done;

  // Split to FIFO
  logic                  cmd_push;
  logic                  cmd_full;
  logic [CmdWidth-1:0]   cmd_wdata;
  logic [CmdWidth-1:0]   cmd_rdata;
  logic                  cmd_empty;

  vmem_req_check u_req_check (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_id_i        (req_id_i),
    .req_is_load_i   (req_is_load_i),
    .req_addr_i      (req_addr_i),
    .req_vl_i        (req_vl_i),
    .req_vew_i       (req_vew_i),
    .vinsn_running_i (vinsn_running_i),
    .ack_o           (ack_o),
    .error_o         (error_o),
    .ack_id_o        (ack_id_o),
    .acc_valid_o     (acc_valid),
    .acc_ready_i     (acc_ready),
    .acc_is_load_o   (acc_is_load),
    .acc_addr_o      (acc_addr),
    .acc_vl_o        (acc_vl),
    .acc_vew_o       (acc_vew),
    .acc_done_i      (acc_done)
  );

  vmem_burst_split u_burst_split (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acc_valid_i   (acc_valid),
    .acc_ready_o   (acc_ready),
    .acc_is_load_i (acc_is_load),
    .acc_addr_i    (acc_addr),
    .acc_vl_i      (acc_vl),
    .acc_vew_i     (acc_vew),
    .acc_done_o    (acc_done),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .ar_addr_o     (ar_addr_o),
    .ar_len_o      (ar_len_o),
    .ar_size_o     (ar_size_o),
    .ar_burst_o    (ar_burst_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .aw_addr_o     (aw_addr_o),
    .aw_len_o      (aw_len_o),
    .aw_size_o     (aw_size_o),
    .aw_burst_o    (aw_burst_o),
    .cmd_full_i    (cmd_full),
    .cmd_push_o    (cmd_push),
    .cmd_wdata_o   (cmd_wdata)
  );

  // Pop on the load/store handshake
  vmem_cmd_fifo #(
    .DEPTH (CmdDepth),
    .WIDTH (CmdWidth)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (cmd_push),
    .data_i  (cmd_wdata),
    .full_o  (cmd_full),
    .pop_i   (cmd_valid_o && cmd_ready_i),
    .data_o  (cmd_rdata),
    .empty_o (cmd_empty)
  );

  // Command word is {addr, len, is_load}
  assign cmd_valid_o   = !cmd_empty;
  assign cmd_addr_o    = cmd_rdata[CmdWidth-1 -: AddrWidth];
  assign cmd_len_o     = cmd_rdata[AxLenWidth:1];
  assign cmd_is_load_o = cmd_rdata[0];

endmodule

`default_nettype wire

//--- verilog/vmem_cmd_fifo.sv
// Stage 3 of the address generator, a circular FIFO of burst commands for the load/store units
`default_nettype none

module vmem_cmd_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o
);

  localparam int unsigned PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntWidth = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]    mem_q [DEPTH];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntWidth'(DEPTH));
  assign empty_o = (count_q == '0);

  // Overflowing pushes and underflowing pops are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head entry, visible the cycle after its push
  assign data_o = mem_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      // Pointers wrap explicitly, so DEPTH need not be a power of two
      if (do_push) begin
        wptr_q <= (wptr_q == PtrWidth'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PtrWidth'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vmem_burst_split.sv
// Stage 2 of the address generator, splits one access into page-safe AXI bursts on AR or AW
`default_nettype none

module vmem_burst_split (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Access from the check stage
  input  logic                             acc_valid_i,
  output logic                             acc_ready_o,
  input  logic                             acc_is_load_i,
  input  logic [vmem_pkg::AddrWidth-1:0]   acc_addr_i,
  input  logic [vmem_pkg::VlWidth-1:0]     acc_vl_i,
  input  vmem_pkg::vew_e                   acc_vew_i,
  output logic                             acc_done_o,
  // AXI read address channel
  output logic                             ar_valid_o,
  input  logic                             ar_ready_i,
  output logic [vmem_pkg::AddrWidth-1:0]   ar_addr_o,
  output logic [vmem_pkg::AxLenWidth-1:0]  ar_len_o,
  output logic [2:0]                       ar_size_o,
  output logic [1:0]                       ar_burst_o,
  // AXI write address channel
  output logic                             aw_valid_o,
  input  logic                             aw_ready_i,
  output logic [vmem_pkg::AddrWidth-1:0]   aw_addr_o,
  output logic [vmem_pkg::AxLenWidth-1:0]  aw_len_o,
  output logic [2:0]                       aw_size_o,
  output logic [1:0]                       aw_burst_o,
  // Burst commands towards the FIFO
  input  logic                             cmd_full_i,
  output logic                             cmd_push_o,
  output logic [vmem_pkg::CmdWidth-1:0]    cmd_wdata_o
);

  import vmem_pkg::*;

  // Current access
  logic                    busy_q;
  logic [AddrWidth-1:0]    addr_q;
  logic [VlWidth-1:0]      rem_q;
  vew_e                    vew_q;
  logic                    is_load_q;

  logic                    take;
  logic                    ax_valid;
  logic                    fire;
  logic                    last_burst;

  // Burst geometry
  logic [AddrWidth-1:0]    start_addr;
  logic [AddrWidth-1:0]    last_byte;
  logic [AddrWidth-1:0]    end_addr;
  logic [AddrWidth-1:0]    burst_end;
  logic [AddrWidth-1:0]    offset;
  logic [BeatCntWidth-1:0] span_beats;
  logic [BeatCntWidth-1:0] beats;
  logic [AxLenWidth-1:0]   burst_len;
  logic [PageBits:0]       burst_bytes;
  logic [PageBits:0]       elem_bytes;
  logic [PageBits:0]       covered;

  // Ready again only once the last burst has gone out
  assign acc_ready_o = !busy_q;
  assign take        = acc_valid_i && acc_ready_o;

  // Valid waits only for FIFO room, never for the AXI ready
  // Room cannot vanish without a push, so valid holds until the burst fires
  assign ax_valid   = busy_q && !cmd_full_i;
  assign ar_valid_o = ax_valid && is_load_q;
  assign aw_valid_o = ax_valid && !is_load_q;
  assign fire       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  always_comb begin
    // Burst starts on the beat that holds the current address
    start_addr = {addr_q[AddrWidth-1:BeatBits], {BeatBits{1'b0}}};

    // Last byte of the remaining elements, rounded up to the end of its beat
    last_byte = addr_q + (AddrWidth'(rem_q) << vew_q) - 1'b1;
    end_addr  = {last_byte[AddrWidth-1:BeatBits], {BeatBits{1'b1}}};

    // Clip at the end of the 4 KiB page
    if (end_addr[AddrWidth-1:PageBits] != start_addr[AddrWidth-1:PageBits]) begin
      end_addr = {start_addr[AddrWidth-1:PageBits], {PageBits{1'b1}}};
    end

    // Both ends now lie in one page, so the page offsets give the beat count
    span_beats = {1'b0, end_addr[PageBits-1:BeatBits]}
               - {1'b0, start_addr[PageBits-1:BeatBits]} + 1'b1;

    // Clip to the AXI4 burst limit
    if (span_beats > BeatCntWidth'(MaxBeats)) begin
      beats = BeatCntWidth'(MaxBeats);
    end else begin
      beats = span_beats;
    end

    burst_end = start_addr + (AddrWidth'(beats) << BeatBits) - 1'b1;
    burst_len = AxLenWidth'(beats - 1'b1);

    // Elements touched by this burst, a partial element counts as covered
    offset      = burst_end - addr_q;
    burst_bytes = offset[PageBits:0] + 1'b1;
    elem_bytes  = {{PageBits{1'b0}}, 1'b1} << vew_q;
    covered     = (burst_bytes + elem_bytes - 1'b1) >> vew_q;
    last_burst  = VlWidth'(covered) >= rem_q;
  end

  // Payload is held in registers, stable while valid waits for ready
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = burst_len;
  assign ar_size_o  = AxSize;
  assign ar_burst_o = BurstIncr;
  assign aw_addr_o  = addr_q;
  assign aw_len_o   = burst_len;
  assign aw_size_o  = AxSize;
  assign aw_burst_o = BurstIncr;

  // Command copy pushed together with the AXI handshake
  assign cmd_push_o  = fire;
  assign cmd_wdata_o = {addr_q, burst_len, is_load_q};
  assign acc_done_o  = fire && last_burst;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (take) begin
      busy_q <= 1'b1;
    end else if (fire && last_burst) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      addr_q    <= acc_addr_i;
      rem_q     <= acc_vl_i;
      vew_q     <= acc_vew_i;
      is_load_q <= acc_is_load_i;
    end else if (fire) begin
      // Next burst picks up right after this one
      addr_q <= burst_end + 1'b1;
      rem_q  <= last_burst ? '0 : rem_q - VlWidth'(covered);
    end
  end

endmodule

`default_nettype wire

//--- verilog/vmem_req_check.sv
// Stage 1 of the address generator, accepts sequencer requests, checks alignment and acknowledges
`default_nettype none

module vmem_req_check (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Sequencer request
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  input  logic [vmem_pkg::IdWidth-1:0]    req_id_i,
  input  logic                            req_is_load_i,
  input  logic [vmem_pkg::AddrWidth-1:0]  req_addr_i,
  input  logic [vmem_pkg::VlWidth-1:0]    req_vl_i,
  input  vmem_pkg::vew_e                  req_vew_i,
  input  logic [vmem_pkg::NrVInsn-1:0]    vinsn_running_i,
  // Acknowledge back to the sequencer
  output logic                            ack_o,
  output logic                            error_o,
  output logic [vmem_pkg::IdWidth-1:0]    ack_id_o,
  // Access towards the burst split stage
  output logic                            acc_valid_o,
  input  logic                            acc_ready_i,
  output logic                            acc_is_load_o,
  output logic [vmem_pkg::AddrWidth-1:0]  acc_addr_o,
  output logic [vmem_pkg::VlWidth-1:0]    acc_vl_o,
  output vmem_pkg::vew_e                  acc_vew_o,
  input  logic                            acc_done_i
);

  import vmem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY
  } state_e;

  state_e               state_q, state_d;
  logic [NrVInsn-1:0]   running_q, running_d;
  logic                 init_q;
  logic                 handed_q, handed_d;
  logic                 done_ack_q;

  // Registered request
  logic [IdWidth-1:0]   id_q;
  logic                 is_load_q;
  logic [AddrWidth-1:0] addr_q;
  logic [VlWidth-1:0]   vl_q;
  vew_e                 vew_q;

  logic                 accept;
  logic                 misaligned;
  logic                 check_ok;

  // Held low until the first edge after reset, and while an id is still running here
  assign req_ready_o = init_q && (state_q == IDLE) && !running_q[req_id_i];
  assign accept      = req_valid_i && req_ready_o;

  // Elements are at most 8 bytes wide, so three low bits cover every width
  assign misaligned = |(addr_q[2:0] & ((3'd1 << vew_q) - 3'd1));
  // Zero-length accesses are answered here and never reach the split stage
  assign check_ok   = !misaligned && (vl_q != '0);

  // Offered from the CHECK cycle on, until the split stage has taken it
  assign acc_valid_o   = ((state_q == CHECK) && check_ok) || ((state_q == BUSY) && !handed_q);
  assign acc_is_load_o = is_load_q;
  assign acc_addr_o    = addr_q;
  assign acc_vl_o      = vl_q;
  assign acc_vew_o     = vew_q;

  // Early answer in CHECK, or one cycle after the last burst
  assign ack_o    = ((state_q == CHECK) && !check_ok) || done_ack_q;
  assign error_o  = (state_q == CHECK) && misaligned;
  assign ack_id_o = id_q;

  always_comb begin
    state_d  = state_q;
    handed_d = handed_q;

    // An id leaves the mask once the sequencer drops it
    running_d = running_q & vinsn_running_i;
    if (accept) begin
      running_d[req_id_i] = 1'b1;
    end

    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (!check_ok) begin
          state_d = IDLE;
        end else begin
          state_d  = BUSY;
          handed_d = acc_ready_i;
        end
      end
      BUSY: begin
        if (acc_valid_o && acc_ready_i) begin
          handed_d = 1'b1;
        end
        // Last burst fired, acknowledge next cycle
        if (acc_done_i) begin
          state_d  = IDLE;
          handed_d = 1'b0;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      running_q  <= '0;
      init_q     <= 1'b0;
      handed_q   <= 1'b0;
      done_ack_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      running_q  <= running_d;
      init_q     <= 1'b1;
      handed_q   <= handed_d;
      done_ack_q <= (state_q == BUSY) && acc_done_i;
    end
  end

  // Request payload, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q      <= req_id_i;
      is_load_q <= req_is_load_i;
      addr_q    <= req_addr_i;
      vl_q      <= req_vl_i;
      vew_q     <= req_vew_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vmem_pkg.sv
// Shared widths, element-width encoding and AXI constants, imported by every address generator stage
`default_nettype none

package vmem_pkg;

  // Byte address width of the memory system
  localparam int unsigned AddrWidth = 32;

  // Bytes per AXI data beat
  localparam int unsigned DataBytes = 8;

  // Address bits below the beat boundary
  localparam int unsigned BeatBits = $clog2(DataBytes);

  // AXI size code, one beat per transfer
  localparam logic [2:0] AxSize = 3'(BeatBits);

  // AXI len field width, beats minus one
  localparam int unsigned AxLenWidth = 8;

  // AXI burst type for incrementing bursts
  localparam logic [1:0] BurstIncr = 2'b01;

  // Vector length counts elements, not bytes
  localparam int unsigned VlWidth = 16;

  // Instruction ids that may be in flight at once
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned IdWidth = $clog2(NrVInsn);

  // AXI bursts must stay inside one 4 KiB page
  localparam int unsigned PageBits = 12;

  // AXI4 limit on beats per INCR burst
  localparam int unsigned MaxBeats = 256;

  // Enough bits to count every beat of a full page, plus one
  localparam int unsigned BeatCntWidth = PageBits - BeatBits + 1;

  // Burst commands buffered towards the load/store units
  localparam int unsigned CmdDepth = 4;

  // Command word is {addr, len, is_load}
  localparam int unsigned CmdWidth = AddrWidth + AxLenWidth + 1;

  // Element width
  // Encoded as log2 of the element size in bytes, so it doubles as a shift amount
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

endpackage

`default_nettype wire
